// File: dv/video_out_tb.sv
/*
 * Testbench for the video output stage
 * Drives small random frames and serial OSD commands and checks the VGA side
 */
`timescale 1ns/1ps
`include "video_config.svh"

module video_out_tb;
	localparam int CLK_NS = 4;
	localparam int CE_DIV = 4;
	localparam int LINE_CE = 100;
	localparam int ACT_X0 = 20;
	localparam int ACT_W = LINE_CE - ACT_X0;
	localparam int HS_LEN = 8;
	localparam int LINES = 30;
	localparam int ACT_Y0 = 6;
	localparam int VS_LEN = 2;
	localparam int SPI_HALF = 4;
	localparam int FRAMES_RUN = 7;
	localparam int SPI_BYTES = 131;
	localparam int TIMEOUT_CYCLES = FRAMES_RUN * LINES * LINE_CE * CE_DIV
		+ 2 * LINE_CE * CE_DIV + SPI_BYTES * 8 * (2 * SPI_HALF + 1)
		+ 3 * 4 * SPI_HALF + 2000;
	// Output is sampled half a cycle into the second cycle after the pixel
	localparam int LAT_NS = 2 * CLK_NS + CLK_NS / 2;

	typedef struct packed {
		logic [63:0]             t;
		logic                    hs, vs, de;
		logic [`VIDEO_OUT_W-1:0] r, g, b;
	} out_s;

	logic clk_sys = 1'b0;
	logic arst_n, ce_pix, hsync, vsync, hblank, vblank, double_en;
	logic [`VIDEO_IN_W-1:0] r, g, b;
	video_pkg::scanline_mode_e scan_mode;
	logic spi_sck, spi_ss_n, spi_di;
	logic [`VIDEO_OUT_W-1:0] vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, vga_de, ce_pix_out;

	out_s        exp_q[$];
	logic [23:0] dbl_q[$];
	logic [23:0] line_pix[ACT_W];
	logic [7:0]  osd_bits[128];
	integer      seed = 57;
	int          cycle = 0;
	int          de_run = 0;
	logic        dbl_check = 1'b0;
	logic        osd_on = 1'b0;
	logic        par = 1'b0;
	logic        prev_hs = 1'b0;
	logic        prev_vs = 1'b0;

	video_out uut (.*);

	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	task automatic report_fail();
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (cycle == TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_fail();
		end
	end

	task automatic check_value(input string name, input logic [7:0] expv, input logic [7:0] got);
		assert (got === expv) else begin
			$display("FAILED %s: expected %h, got %h", name, expv, got);
			report_fail();
		end
	endtask

	// Odd lines darken by the mode with truncation, then the top six bits remain
	function automatic logic [`VIDEO_OUT_W-1:0] plain_colour(input logic [7:0] c, input logic odd);
		logic [7:0] v;
		v = c;
		if (odd) begin
			case (scan_mode)
				video_pkg::dim_25: v = c / 2 + c / 4;
				video_pkg::dim_50: v = c / 2;
				video_pkg::dim_75: v = c / 4;
				default:           v = c;
			endcase
		end
		return v[7 -: `VIDEO_OUT_W];
	endfunction

	function automatic logic [`VIDEO_OUT_W-1:0] osd_colour(input logic [5:0] c, input int ax,
		input int ay);
		int wx, wy;
		wx = ax - `OSD_X0;
		wy = ay - `OSD_Y0;
		if (!osd_on || wx < 0 || wx >= `OSD_W || wy < 0 || wy >= `OSD_H)
			return c;
		// Eight bytes per row with the leftmost pixel in bit 7
		if (osd_bits[wy * (`OSD_W / 8) + wx / 8][7 - wx % 8])
			return '1;
		return c >> 1;
	endfunction

	task automatic drive_line(input int l);
		logic [31:0] rnd;
		logic        hs, vs, hb, vb, de;
		out_s        e;
		for (int p = 0; p < LINE_CE; p++) begin
			@(posedge clk_sys);
			rnd = $random(seed);
			hs = p < HS_LEN;
			vs = l < VS_LEN;
			hb = p < ACT_X0;
			vb = l < ACT_Y0;
			de = !hb && !vb;
			// Parity clears on falling vsync and flips on falling hsync
			if (prev_vs && !vs)
				par = 1'b0;
			else if (prev_hs && !hs)
				par = ~par;
			prev_hs = hs;
			prev_vs = vs;
			ce_pix <= 1'b1;
			hsync <= hs;
			vsync <= vs;
			hblank <= hb;
			vblank <= vb;
			{r, g, b} <= rnd[23:0];
			if (de)
				line_pix[p - ACT_X0] = rnd[23:0];
			e.t = $time;
			e.hs = hs;
			e.vs = vs;
			e.de = de;
			e.r = de ? osd_colour(plain_colour(rnd[23:16], par), p - ACT_X0, l - ACT_Y0) : '0;
			e.g = de ? osd_colour(plain_colour(rnd[15:8], par), p - ACT_X0, l - ACT_Y0) : '0;
			e.b = de ? osd_colour(plain_colour(rnd[7:0], par), p - ACT_X0, l - ACT_Y0) : '0;
			if (!dbl_check)
				exp_q.push_back(e);
			@(posedge clk_sys);
			ce_pix <= 1'b0;
			repeat (CE_DIV - 2) @(posedge clk_sys);
		end
		// The doubler replays each active line twice one input line later
		if (dbl_check && l >= ACT_Y0) begin
			assert (dbl_q.size() < ACT_W) else begin
				$display("Doubler output is more than one input line behind");
				report_fail();
			end
			repeat (2) begin
				foreach (line_pix[i])
					dbl_q.push_back(line_pix[i]);
			end
		end
	endtask

	always @(negedge clk_sys) begin
		out_s        e;
		logic [23:0] px;
		if (ce_pix_out) begin
			if (vga_de) begin
				de_run = de_run + 1;
			end else if (de_run != 0) begin
				check_value("vga_de run length", 8'(ACT_W), 8'(de_run));
				de_run = 0;
			end
			if (dbl_check) begin
				if (vga_de) begin
					assert (dbl_q.size() != 0) else begin
						$display("Doubled pixel arrived before its input line was complete");
						report_fail();
					end
					px = dbl_q.pop_front();
					check_value("vga_r", px[23:18], vga_r);
					check_value("vga_g", px[15:10], vga_g);
					check_value("vga_b", px[7:2], vga_b);
				end
			end else begin
				assert (exp_q.size() != 0) else begin
					$display("Output pixel strobe with no input pixel pending");
					report_fail();
				end
				e = exp_q.pop_front();
				assert ($time - e.t == LAT_NS) else begin
					$display("Output pixel came %0d ns after its input, expected %0d ns",
						$time - e.t, LAT_NS);
					report_fail();
				end
				check_value("vga_hs", e.hs, vga_hs);
				check_value("vga_vs", e.vs, vga_vs);
				check_value("vga_de", e.de, vga_de);
				check_value("vga_r", e.r, vga_r);
				check_value("vga_g", e.g, vga_g);
				check_value("vga_b", e.b, vga_b);
			end
		end
	end

	task automatic wait_drain();
		while (exp_q.size() != 0 || dbl_q.size() != 0)
			@(posedge clk_sys);
	endtask

	task automatic run_frame(input video_pkg::scanline_mode_e mode);
		@(posedge clk_sys);
		scan_mode <= mode;
		for (int l = 0; l < LINES; l++)
			drive_line(l);
		wait_drain();
	endtask

	// Mode 0 and MSB first with data set up half a bit before the rising clock
	task automatic spi_byte(input logic [7:0] v);
		for (int i = 7; i >= 0; i--) begin
			@(posedge clk_sys);
			spi_di <= v[i];
			repeat (SPI_HALF) @(posedge clk_sys);
			spi_sck <= 1'b1;
			repeat (SPI_HALF) @(posedge clk_sys);
			spi_sck <= 1'b0;
		end
	endtask

	task automatic send_cmd(input video_pkg::osd_cmd_e cmd, input int n_data);
		repeat (SPI_HALF) @(posedge clk_sys);
		spi_ss_n <= 1'b0;
		repeat (SPI_HALF) @(posedge clk_sys);
		spi_byte(cmd);
		for (int i = 0; i < n_data; i++)
			spi_byte(osd_bits[i]);
		repeat (SPI_HALF) @(posedge clk_sys);
		spi_ss_n <= 1'b1;
		repeat (SPI_HALF) @(posedge clk_sys);
	endtask

	task automatic idle_after_reset();
		repeat (8) begin
			@(negedge clk_sys);
			assert ({vga_de, vga_hs, vga_vs, ce_pix_out} === 4'b0) else begin
				$display("Outputs were not idle after reset before the first pixel");
				report_fail();
			end
		end
	endtask

	task automatic osd_window();
		// Every byte differs and depends on its whole address
		for (int i = 0; i < 128; i++)
			osd_bits[i] = 8'((i * 29) ^ 8'h5a);
		send_cmd(video_pkg::cmd_write, 128);
		send_cmd(video_pkg::cmd_enable, 0);
		osd_on = 1'b1;
		run_frame(video_pkg::none);
	endtask

	task automatic osd_disabled();
		send_cmd(video_pkg::cmd_disable, 0);
		osd_on = 1'b0;
		run_frame(video_pkg::none);
	endtask

	task automatic line_doubling();
		@(posedge clk_sys);
		scan_mode <= video_pkg::none;
		dbl_check = 1'b1;
		// Switch over during vertical blank so no stale line reaches DE
		drive_line(0);
		double_en <= 1'b1;
		for (int l = 1; l < LINES; l++)
			drive_line(l);
		// Two blank lines flush the replay of the last active line
		drive_line(0);
		drive_line(1);
		wait_drain();
	endtask

	initial begin
		arst_n = 1'b0;
		ce_pix = 1'b0;
		r = '0;
		g = '0;
		b = '0;
		hsync = 1'b0;
		vsync = 1'b0;
		hblank = 1'b1;
		vblank = 1'b1;
		double_en = 1'b0;
		scan_mode = video_pkg::none;
		spi_sck = 1'b0;
		spi_ss_n = 1'b1;
		spi_di = 1'b0;
		repeat (2) @(posedge clk_sys);
		arst_n <= 1'b1;
		idle_after_reset();
		run_frame(video_pkg::none);
		run_frame(video_pkg::dim_25);
		run_frame(video_pkg::dim_50);
		run_frame(video_pkg::dim_75);
		osd_window();
		osd_disabled();
		line_doubling();
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: hw/line_doubler.sv
/*
 * Line doubler
 * Buffers each active input line and replays it twice at double pixel rate,
 * or hands the input straight through when doubling is off
 */
`timescale 1ns/1ps
`include "video_config.svh"

module line_doubler #(
	parameter int LINE_LENGTH = 768
) (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   ce_pix,
	input  logic                   double_en,
	input  logic [`VIDEO_IN_W-1:0] r_in,
	input  logic [`VIDEO_IN_W-1:0] g_in,
	input  logic [`VIDEO_IN_W-1:0] b_in,
	input  logic                   hs_in,
	input  logic                   vs_in,
	input  logic                   hb_in,
	input  logic                   vb_in,
	output logic                   pix_ce,
	output logic [`VIDEO_IN_W-1:0] pix_r,
	output logic [`VIDEO_IN_W-1:0] pix_g,
	output logic [`VIDEO_IN_W-1:0] pix_b,
	output logic                   pix_hs,
	output logic                   pix_vs,
	output logic                   pix_hb,
	output logic                   pix_vb
);
	localparam int AW = $clog2(LINE_LENGTH);
	localparam int HW = AW + 2;
	localparam int CW = 3 * `VIDEO_IN_W;

	// Two line halves, one being written while the other is replayed
	logic [CW-1:0] line_buf [2*LINE_LENGTH];

	logic          hs_prev, hb_prev;
	logic          line_start, wr_en;
	logic [HW-1:0] hcnt_in, pix_idx;
	logic [HW-1:0] hs_width, act_start;
	logic [AW:0]   wr_addr, wr_ptr;
	logic          wr_half, line_vs, line_vb;

	// Geometry of the line being replayed
	logic          rd_half, rd_vs, rd_vb;
	logic [HW-1:0] rd_len, rd_hs_width, rd_act_start;
	logic [AW:0]   rd_act_cnt;

	logic          out_run, phase, oc_active;
	logic [HW-1:0] oc;
	logic [AW:0]   rd_addr, rd_ptr;
	logic          d_ce, d_hs, d_vs, d_hb, d_vb;
	logic [CW-1:0] d_rgb;

	// Index of the current input pixel counted from the hsync rise
	assign line_start = ce_pix && hs_in && !hs_prev;
	assign pix_idx    = line_start ? '0 : hcnt_in + 1'b1;
	assign wr_en      = ce_pix && double_en && !hb_in;
	assign wr_ptr     = wr_half ? wr_addr + (AW+1)'(LINE_LENGTH) : wr_addr;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs_prev      <= 1'b0;
			hb_prev      <= 1'b1;
			hcnt_in      <= '0;
			hs_width     <= '0;
			act_start    <= '0;
			wr_addr      <= '0;
			wr_half      <= 1'b0;
			line_vs      <= 1'b0;
			line_vb      <= 1'b1;
			rd_half      <= 1'b0;
			rd_len       <= '0;
			rd_hs_width  <= '0;
			rd_act_start <= '0;
			rd_act_cnt   <= '0;
			rd_vs        <= 1'b0;
			rd_vb        <= 1'b1;
		end else if (ce_pix) begin
			hs_prev <= hs_in;
			hb_prev <= hb_in;
			hcnt_in <= pix_idx;
			if (hs_prev && !hs_in)
				hs_width <= pix_idx;
			if (hb_prev && !hb_in)
				act_start <= pix_idx;
			if (!hb_in) begin
				wr_addr <= wr_addr + 1'b1;
				line_vb <= vb_in;
			end
			// Hand the finished line over to the replay side
			if (line_start) begin
				rd_len       <= hcnt_in + 1'b1;
				rd_hs_width  <= hs_width;
				rd_act_start <= act_start;
				rd_act_cnt   <= wr_addr;
				rd_vs        <= line_vs;
				rd_vb        <= line_vb;
				rd_half      <= wr_half;
				wr_half      <= ~wr_half;
				wr_addr      <= '0;
				line_vs      <= vs_in;
				line_vb      <= vb_in;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			line_buf[wr_ptr] <= {r_in, g_in, b_in};
	end

	assign oc_active = (oc >= rd_act_start) && (oc < rd_act_start + rd_act_cnt);
	assign rd_addr   = oc_active ? (AW+1)'(oc - rd_act_start) : '0;
	assign rd_ptr    = rd_half ? rd_addr + (AW+1)'(LINE_LENGTH) : rd_addr;

	// Replay at half the clk_sys rate gives two copies per input line
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			out_run <= 1'b0;
			phase   <= 1'b0;
			oc      <= '0;
			d_ce    <= 1'b0;
			d_hs    <= 1'b0;
			d_vs    <= 1'b0;
			d_hb    <= 1'b1;
			d_vb    <= 1'b1;
		end else begin
			d_ce <= 1'b0;
			if (line_start) begin
				out_run <= 1'b1;
				phase   <= 1'b1;
				oc      <= '0;
			end else if (out_run) begin
				phase <= ~phase;
				if (phase) begin
					d_ce <= 1'b1;
					d_hs <= oc < rd_hs_width;
					d_vs <= rd_vs;
					d_hb <= !oc_active;
					d_vb <= rd_vb;
					oc   <= (oc == rd_len - 1'b1) ? '0 : oc + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (out_run && phase && !line_start)
			d_rgb <= line_buf[rd_ptr];
	end

	assign pix_ce = double_en ? d_ce : ce_pix;
	assign pix_r  = double_en ? d_rgb[CW-1 -: `VIDEO_IN_W] : r_in;
	assign pix_g  = double_en ? d_rgb[2*`VIDEO_IN_W-1 -: `VIDEO_IN_W] : g_in;
	assign pix_b  = double_en ? d_rgb[`VIDEO_IN_W-1:0] : b_in;
	assign pix_hs = double_en ? d_hs : hs_in;
	assign pix_vs = double_en ? d_vs : vs_in;
	assign pix_hb = double_en ? d_hb : hb_in;
	assign pix_vb = double_en ? d_vb : vb_in;

	// An active input line longer than the buffer would overwrite the other half
	a_wr_in_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wr_en |-> wr_addr < LINE_LENGTH)
		else $error("line_doubler: active line exceeds LINE_LENGTH");

endmodule

// File: hw/osd_overlay.sv
/*
 * OSD overlay
 * Serial command receiver and a 64x16 one-bit bitmap drawn over the picture
 */
`timescale 1ns/1ps
`include "video_config.svh"

module osd_overlay (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    spi_sck,
	input  logic                    spi_ss_n,
	input  logic                    spi_di,
	input  logic                    dim_ce,
	input  logic [`VIDEO_OUT_W-1:0] dim_r,
	input  logic [`VIDEO_OUT_W-1:0] dim_g,
	input  logic [`VIDEO_OUT_W-1:0] dim_b,
	input  logic                    dim_hs,
	input  logic                    dim_vs,
	input  logic                    dim_de,
	output logic [`VIDEO_OUT_W-1:0] vga_r,
	output logic [`VIDEO_OUT_W-1:0] vga_g,
	output logic [`VIDEO_OUT_W-1:0] vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs,
	output logic                    vga_de,
	output logic                    ce_pix_out
);
	localparam int BYTES = `OSD_W * `OSD_H / 8;
	localparam int BW    = $clog2(BYTES);
	localparam int PW    = 11;

	logic [7:0]    bitmap [BYTES];

	logic [2:0]    sck_sync;
	logic [1:0]    ss_sync, di_sync;
	logic          sck_rise, byte_done, bm_we;
	logic [2:0]    bit_cnt;
	logic [7:0]    shift, byte_in;
	logic          first_byte, wr_mode, osd_en;
	logic [BW:0]   wr_addr;

	logic          de_prev, vs_prev;
	logic [PW-1:0] px_cnt, ln_cnt, wx, wy;
	logic          in_win, bm_bit;
	logic [BW-1:0] bm_addr;

	// Two-stage synchronizers keep data aligned with the clock edge detect
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sck_sync <= '0;
			ss_sync  <= 2'b11;
			di_sync  <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], spi_sck};
			ss_sync  <= {ss_sync[0], spi_ss_n};
			di_sync  <= {di_sync[0], spi_di};
		end
	end

	assign sck_rise  = sck_sync[1] && !sck_sync[2] && !ss_sync[1];
	assign byte_in   = {shift[6:0], di_sync[1]};
	assign byte_done = sck_rise && bit_cnt == 3'd7;
	assign bm_we     = byte_done && !first_byte && wr_mode;

	always_ff @(posedge clk_sys) begin
		if (sck_rise)
			shift <= byte_in;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt    <= '0;
			first_byte <= 1'b1;
			wr_mode    <= 1'b0;
			wr_addr    <= '0;
			osd_en     <= 1'b0;
		end else if (ss_sync[1]) begin
			bit_cnt    <= '0;
			first_byte <= 1'b1;
			wr_mode    <= 1'b0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 1'b1;
			if (byte_done) begin
				first_byte <= 1'b0;
				if (first_byte) begin
					case (byte_in)
						video_pkg::cmd_enable:  osd_en <= 1'b1;
						video_pkg::cmd_disable: osd_en <= 1'b0;
						video_pkg::cmd_write: begin
							wr_mode <= 1'b1;
							wr_addr <= '0;
						end
						default: ;
					endcase
				end else if (wr_mode) begin
					wr_addr <= wr_addr + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < BYTES; i++)
				bitmap[i] <= '0;
		end else if (bm_we) begin
			bitmap[wr_addr[BW-1:0]] <= byte_in;
		end
	end

	// Position in output active pixels and active lines
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			de_prev <= 1'b0;
			vs_prev <= 1'b0;
			px_cnt  <= '0;
			ln_cnt  <= '0;
		end else if (dim_ce) begin
			de_prev <= dim_de;
			vs_prev <= dim_vs;
			if (de_prev && !dim_de) begin
				px_cnt <= '0;
				ln_cnt <= ln_cnt + 1'b1;
			end else if (dim_de) begin
				px_cnt <= px_cnt + 1'b1;
			end
			if (vs_prev && !dim_vs)
				ln_cnt <= '0;
		end
	end

	assign wx      = px_cnt - PW'(`OSD_X0);
	assign wy      = ln_cnt - PW'(`OSD_Y0);
	assign in_win  = osd_en && dim_de &&
		px_cnt >= `OSD_X0 && px_cnt < `OSD_X0 + `OSD_W &&
		ln_cnt >= `OSD_Y0 && ln_cnt < `OSD_Y0 + `OSD_H;
	// Eight bytes per row with bit 7 as the leftmost pixel
	assign bm_addr = BW'(wy * (`OSD_W / 8) + wx[PW-1:3]);
	assign bm_bit  = bitmap[bm_addr][3'd7 - wx[2:0]];

	function automatic logic [`VIDEO_OUT_W-1:0] mix(
		input logic [`VIDEO_OUT_W-1:0] c,
		input logic win,
		input logic px_on
	);
		if (!win)
			return c;
		return px_on ? {`VIDEO_OUT_W{1'b1}} : c >> 1;
	endfunction

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ce_pix_out <= 1'b0;
			vga_hs     <= 1'b0;
			vga_vs     <= 1'b0;
			vga_de     <= 1'b0;
		end else begin
			ce_pix_out <= dim_ce;
			if (dim_ce) begin
				vga_hs <= dim_hs;
				vga_vs <= dim_vs;
				vga_de <= dim_de;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dim_ce) begin
			vga_r <= mix(dim_r, in_win, bm_bit);
			vga_g <= mix(dim_g, in_win, bm_bit);
			vga_b <= mix(dim_b, in_win, bm_bit);
		end
	end

	// A write command carries at most one full bitmap
	a_bm_addr: assert property (@(posedge clk_sys) disable iff (!arst_n)
		bm_we |-> wr_addr < BYTES)
		else $error("osd_overlay: bitmap write past the last byte");

endmodule

// File: hw/scanline_dimmer.sv
/*
 * Scanline dimmer
 * Darkens alternate output lines, cuts colour to VGA depth and forms DE
 */
`timescale 1ns/1ps
`include "video_config.svh"

module scanline_dimmer (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      pix_ce,
	input  logic [`VIDEO_IN_W-1:0]    pix_r,
	input  logic [`VIDEO_IN_W-1:0]    pix_g,
	input  logic [`VIDEO_IN_W-1:0]    pix_b,
	input  logic                      pix_hs,
	input  logic                      pix_vs,
	input  logic                      pix_hb,
	input  logic                      pix_vb,
	input  video_pkg::scanline_mode_e scan_mode,
	output logic                      dim_ce,
	output logic [`VIDEO_OUT_W-1:0]   dim_r,
	output logic [`VIDEO_OUT_W-1:0]   dim_g,
	output logic [`VIDEO_OUT_W-1:0]   dim_b,
	output logic                      dim_hs,
	output logic                      dim_vs,
	output logic                      dim_de
);
	logic                   hs_prev, vs_prev, hb_prev;
	logic                   odd_line, de_now;
	logic [`VIDEO_IN_W-1:0] sc_r, sc_g, sc_b;

	// Dim levels are built from truncated shifted copies
	function automatic logic [`VIDEO_IN_W-1:0] scale(
		input logic [`VIDEO_IN_W-1:0] c,
		input video_pkg::scanline_mode_e mode,
		input logic odd
	);
		logic [`VIDEO_IN_W-1:0] half, quarter;
		half    = c >> 1;
		quarter = c >> 2;
		if (!odd)
			return c;
		case (mode)
			video_pkg::dim_25: return half + quarter;
			video_pkg::dim_50: return half;
			video_pkg::dim_75: return quarter;
			default:           return c;
		endcase
	endfunction

	assign sc_r = scale(pix_r, scan_mode, odd_line);
	assign sc_g = scale(pix_g, scan_mode, odd_line);
	assign sc_b = scale(pix_b, scan_mode, odd_line);

	// DE opens on the first active pixel and closes as hblank rises
	always_comb begin
		de_now = dim_de;
		if (hb_prev && !pix_hb)
			de_now = !pix_vb;
		else if (!hb_prev && pix_hb)
			de_now = 1'b0;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dim_ce   <= 1'b0;
			dim_hs   <= 1'b0;
			dim_vs   <= 1'b0;
			dim_de   <= 1'b0;
			hs_prev  <= 1'b0;
			vs_prev  <= 1'b0;
			hb_prev  <= 1'b1;
			odd_line <= 1'b0;
		end else begin
			dim_ce <= pix_ce;
			if (pix_ce) begin
				hs_prev <= pix_hs;
				vs_prev <= pix_vs;
				hb_prev <= pix_hb;
				if (vs_prev && !pix_vs)
					odd_line <= 1'b0;
				else if (hs_prev && !pix_hs)
					odd_line <= ~odd_line;
				dim_hs <= pix_hs;
				dim_vs <= pix_vs;
				dim_de <= de_now;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pix_ce) begin
			dim_r <= de_now ? sc_r[`VIDEO_IN_W-1 -: `VIDEO_OUT_W] : '0;
			dim_g <= de_now ? sc_g[`VIDEO_IN_W-1 -: `VIDEO_OUT_W] : '0;
			dim_b <= de_now ? sc_b[`VIDEO_IN_W-1 -: `VIDEO_OUT_W] : '0;
		end
	end

endmodule

// File: hw/video_config.svh
/*
 * Video output configuration
 * Line buffer depth, colour widths and OSD window geometry
 */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Longest active line the doubler buffer can hold
`define VIDEO_LINE_LEN 768

// Colour component widths at the core side and at the VGA side
`define VIDEO_IN_W  8
`define VIDEO_OUT_W 6

// OSD window, in output active pixels and active lines
`define OSD_X0 (8)
`define OSD_Y0 (4)
`define OSD_W  (64)
`define OSD_H  (16)

`endif

// File: hw/video_out.sv
/*
 * Video output stage
 * Line doubler, scanline dimmer and OSD overlay in series
 */
`timescale 1ns/1ps
`include "video_config.svh"

module video_out (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      ce_pix,
	input  logic [`VIDEO_IN_W-1:0]    r,
	input  logic [`VIDEO_IN_W-1:0]    g,
	input  logic [`VIDEO_IN_W-1:0]    b,
	input  logic                      hsync,
	input  logic                      vsync,
	input  logic                      hblank,
	input  logic                      vblank,
	input  logic                      double_en,
	input  video_pkg::scanline_mode_e scan_mode,
	input  logic                      spi_sck,
	input  logic                      spi_ss_n,
	input  logic                      spi_di,
	output logic [`VIDEO_OUT_W-1:0]   vga_r,
	output logic [`VIDEO_OUT_W-1:0]   vga_g,
	output logic [`VIDEO_OUT_W-1:0]   vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs,
	output logic                      vga_de,
	output logic                      ce_pix_out
);
	logic                    pix_ce, pix_hs, pix_vs, pix_hb, pix_vb;
	logic [`VIDEO_IN_W-1:0]  pix_r, pix_g, pix_b;
	logic                    dim_ce, dim_hs, dim_vs, dim_de;
	logic [`VIDEO_OUT_W-1:0] dim_r, dim_g, dim_b;

	line_doubler #(
		.LINE_LENGTH(`VIDEO_LINE_LEN)
	) u_doubler (
		.clk_sys(clk_sys), .arst_n(arst_n), .ce_pix(ce_pix), .double_en(double_en),
		.r_in(r), .g_in(g), .b_in(b),
		.hs_in(hsync), .vs_in(vsync), .hb_in(hblank), .vb_in(vblank),
		.pix_ce(pix_ce), .pix_r(pix_r), .pix_g(pix_g), .pix_b(pix_b),
		.pix_hs(pix_hs), .pix_vs(pix_vs), .pix_hb(pix_hb), .pix_vb(pix_vb)
	);

	scanline_dimmer u_dimmer (
		.clk_sys(clk_sys), .arst_n(arst_n), .pix_ce(pix_ce),
		.pix_r(pix_r), .pix_g(pix_g), .pix_b(pix_b),
		.pix_hs(pix_hs), .pix_vs(pix_vs), .pix_hb(pix_hb), .pix_vb(pix_vb),
		.scan_mode(scan_mode),
		.dim_ce(dim_ce), .dim_r(dim_r), .dim_g(dim_g), .dim_b(dim_b),
		.dim_hs(dim_hs), .dim_vs(dim_vs), .dim_de(dim_de)
	);

	osd_overlay u_osd (
		.clk_sys(clk_sys), .arst_n(arst_n),
		.spi_sck(spi_sck), .spi_ss_n(spi_ss_n), .spi_di(spi_di),
		.dim_ce(dim_ce), .dim_r(dim_r), .dim_g(dim_g), .dim_b(dim_b),
		.dim_hs(dim_hs), .dim_vs(dim_vs), .dim_de(dim_de),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_de(vga_de), .ce_pix_out(ce_pix_out)
	);

endmodule

// File: hw/video_pkg.sv
/*
 * Video output types
 * Scanline dimming modes and OSD serial command codes
 */
package video_pkg;

	// How much odd output lines are darkened
	typedef enum logic [1:0] {
		none   = 2'd0,
		dim_25 = 2'd1,
		dim_50 = 2'd2,
		dim_75 = 2'd3
	} scanline_mode_e;

	// First byte of a serial command frame
	// Codes not listed here are ignored by the receiver
	typedef enum logic [7:0] {
		cmd_disable = 8'h40,
		cmd_enable  = 8'h41,
		cmd_write   = 8'h20
	} osd_cmd_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# Compile the video output testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f video_out.f --top-module video_out_tb \
	-Mdir obj_dir -o video_out_sim

./obj_dir/video_out_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx '>>> PASS' sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// File: video_out.f
+incdir+hw
hw/video_pkg.sv
hw/line_doubler.sv
hw/scanline_dimmer.sv
hw/osd_overlay.sv
hw/video_out.sv
dv/video_out_tb.sv
